// ==== src.f ====
+incdir+design
design/dsp_cfg_pkg.sv
design/dsp_data_pkg.sv
design/ffe_slicer.sv
design/channel_filter.sv
design/code_delay_line.sv
design/error_detector.sv
design/datapath_core.sv
sim/datapath_core_assert.sv
sim/datapath_core_tb.sv

// ==== Bender.yml ====
package:
  name: datapath_core

sources:
  - include_dirs:
      - design
    files:
      - design/dsp_cfg_pkg.sv
      - design/dsp_data_pkg.sv
      - design/ffe_slicer.sv
      - design/channel_filter.sv
      - design/code_delay_line.sv
      - design/error_detector.sv
      - design/datapath_core.sv
  - target: simulation
    files:
      - sim/datapath_core_assert.sv
      - sim/datapath_core_tb.sv

// ==== sim/datapath_core_tb.sv ====
`timescale 1ns/1ns

`include "dsp_defines.svh"

module datapath_core_tb;
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    localparam int W = `CHANNEL_WIDTH;
    localparam int N_ID = 40;
    localparam int N_RAND = 200;
    localparam int N_MASK = 30;
    localparam int N_GAP = 100;
    localparam int MAX_GAP = 3;
    localparam int N_DIR = 60;
    localparam int STIM_CYCLES = 10 + N_ID + N_RAND + 4 * N_MASK + N_GAP * (MAX_GAP + 1)
                                 + N_DIR + 8 * 10;

    logic        clk;
    logic        rst_n_i;
    logic        codes_valid_i;
    code_word_t  adc_codes_i;
    dsp_cfg_t    cfg_i;
    logic        out_valid_o;
    detect_out_t detect_o;

    integer      seed;
    int          cyc;
    int          errors;
    int          checks;
    int          tests;
    int          flip_cur_seen;
    int          flip_prev_seen;
    detect_out_t exp_q[$];
    int          stamp_q[$];

    // Model history, reset state stands for code 0 and symbol -1
    code_word_t  ref_prev_codes;
    bit_word_t   ref_prev_bits;
    logic        ref_prev_last;

    datapath_core datapath_core_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .codes_valid_i (codes_valid_i),
        .adc_codes_i   (adc_codes_i),
        .cfg_i         (cfg_i),
        .out_valid_o   (out_valid_o),
        .detect_o      (detect_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int cost_of(input int a, input int b);
        return a * a + b * b;
    endfunction

    function detect_out_t ref_detect(input code_word_t c, input dsp_cfg_t cfg);
        detect_out_t                          r;
        bit_word_t                            b;
        int                                   acc;
        int                                   k;
        int                                   cv;
        int                                   tap;
        int                                   e[W];
        int                                   d0;
        int                                   d1;
        int                                   s_cur;
        int                                   s_prev;
        int                                   c0;
        int                                   c1;
        int                                   c2;
        logic                                 bv;
        logic signed [`FFE_OUT_PRECISION-1:0] f;
        logic signed [`EST_CODE_PRECISION-1:0] est;
        for (int i = 0; i < W; i++) begin
            acc = 0;
            for (int j = 0; j < `FFE_LENGTH; j++) begin
                k = i - j;
                cv = (k >= 0) ? c[k] : ref_prev_codes[k + W];
                if (!cfg.disable_product[j]) acc = acc + cfg.weights[j] * cv;
            end
            f = acc >>> cfg.ffe_shift;
            b[i] = (f >= cfg.thresh);
        end
        for (int i = 0; i < W; i++) begin
            acc = 0;
            for (int j = 0; j < `CHAN_DEPTH; j++) begin
                k = i - j;
                bv = (k >= 0) ? b[k] : ref_prev_bits[k + W];
                tap = cfg.channel_est[j];
                acc = bv ? acc + tap : acc - tap;
            end
            est = acc >>> cfg.channel_shift;
            cv = c[i];
            e[i] = est - cv;
        end
        tap = cfg.channel_est[0];
        d0 = (2 * tap) >>> cfg.channel_shift;
        tap = cfg.channel_est[1];
        d1 = (2 * tap) >>> cfg.channel_shift;
        for (int i = 0; i < W; i++) begin
            s_cur = b[i] ? 1 : -1;
            if (i == 0) s_prev = ref_prev_last ? 1 : -1;
            else s_prev = b[i - 1] ? 1 : -1;
            c0 = cost_of(e[i], (i + 1 < W) ? e[(i + 1) % W] : 0);
            c1 = cost_of(e[i] - s_cur * d0, (i + 1 < W) ? e[(i + 1) % W] - s_cur * d1 : 0);
            c2 = cost_of(e[i] - s_prev * d1, (i + 1 < W) ? e[(i + 1) % W] : 0);
            r.decisions[i] = MMSE_KEEP;
            if (c1 < c0 && c1 <= c2) r.decisions[i] = MMSE_FLIP_CUR;
            else if (c2 < c0 && c2 < c1) r.decisions[i] = MMSE_FLIP_PREV;
        end
        r.bits = b;
        ref_prev_codes = c;
        ref_prev_bits = b;
        ref_prev_last = b[W - 1];
        return r;
    endfunction

    task automatic drive_word(input code_word_t c);
        @(posedge clk);
        #2;
        codes_valid_i = 1'b1;
        adc_codes_i = c;
        exp_q.push_back(ref_detect(c, cfg_i));
        stamp_q.push_back(cyc);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            codes_valid_i = 1'b0;
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        idle(1);
        while (exp_q.size() != 0) @(posedge clk);
        idle(4);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic random_cfg();
        cfg_i.weights = $random(seed);
        cfg_i.disable_product = '0;
        cfg_i.ffe_shift = $random(seed) & 7;
        cfg_i.thresh = $random(seed);
        cfg_i.channel_est = $random(seed);
        cfg_i.channel_shift = $random(seed) & 3;
    endtask

    // Comparing process, sampled away from the active edge
    always @(negedge clk) begin
        detect_out_t exp;
        int          stamp;
        if (rst_n_i && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Output word arrived at %0t with no expected word queued", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                checks++;
                if (detect_o.bits != exp.bits) begin
                    $display("CHECK FAILED at %0t: detect_o.bits got %h expected %h",
                             $time, detect_o.bits, exp.bits);
                    errors++;
                end
                if (detect_o.decisions != exp.decisions) begin
                    $display("CHECK FAILED at %0t: detect_o.decisions got %h expected %h",
                             $time, detect_o.decisions, exp.decisions);
                    errors++;
                end
                if (cyc - stamp != 3) begin
                    $display("CHECK FAILED at %0t: out_valid_o latency got %0d expected 3",
                             $time, cyc - stamp);
                    errors++;
                end
                for (int i = 0; i < W; i++) begin
                    if (detect_o.decisions[i] == MMSE_FLIP_CUR) flip_cur_seen++;
                    if (detect_o.decisions[i] == MMSE_FLIP_PREV) flip_prev_seen++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(2 * STIM_CYCLES * 20);
        $display("Timeout: run did not finish within %0d ns", 2 * STIM_CYCLES * 20);
        $display("Checks failed");
        $finish;
    end

    initial begin
        code_word_t c;
        bit_word_t  t;
        logic       last_true;
        int         eb;
        int         k;
        int         s;
        int         sp;
        clk = 1'b0;
        rst_n_i = 1'b0;
        codes_valid_i = 1'b0;
        adc_codes_i = '0;
        cfg_i = '0;
        seed = 68854;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        flip_cur_seen = 0;
        flip_prev_seen = 0;
        ref_prev_codes = '0;
        ref_prev_bits = '0;
        ref_prev_last = 1'b0;

        // Reset, outputs must stay quiet during and after it
        eb = errors;
        for (int n = 0; n < 12; n++) begin
            @(posedge clk);
            #2;
            if (n == 9) rst_n_i = 1'b1;
            @(negedge clk);
            checks++;
            if (out_valid_o !== 1'b0 || detect_o !== '0) begin
                $display("CHECK FAILED at %0t: out_valid_o/detect_o got %b/%h expected 0/0",
                         $time, out_valid_o, detect_o);
                errors++;
            end
        end
        close_test("reset", eb);

        eb = errors;
        cfg_i.weights[0] = 8'sd1;
        for (int i = 0; i < N_ID; i++) drive_word($random(seed));
        close_test("identity", eb);

        eb = errors;
        random_cfg();
        for (int i = 0; i < N_RAND; i++) drive_word($random(seed));
        close_test("random", eb);

        eb = errors;
        for (int m = 0; m < 4; m++) begin
            random_cfg();
            cfg_i.disable_product = (m == 0) ? 3'b001 : (m == 1) ? 3'b110 : 3'b111;
            // All taps off leaves a zero FFE, so the threshold sign decides
            if (m == 2) cfg_i.thresh = 10'sd1;
            if (m == 3) cfg_i.thresh = 10'sd0;
            for (int i = 0; i < N_MASK; i++) drive_word($random(seed));
            idle(1);
            while (exp_q.size() != 0) @(posedge clk);
            idle(1);
        end
        close_test("mask", eb);

        eb = errors;
        random_cfg();
        for (int i = 0; i < N_GAP; i++) begin
            drive_word($random(seed));
            idle({$random(seed)} % (MAX_GAP + 1));
        end
        close_test("gaps", eb);

        // Directed channel 40, 20, 0 with one wrong-sign code per word
        eb = errors;
        cfg_i = '0;
        cfg_i.weights[0] = 8'sd1;
        cfg_i.channel_est[0] = 8'sd40;
        cfg_i.channel_est[1] = 8'sd20;
        last_true = 1'b0;
        flip_cur_seen = 0;
        flip_prev_seen = 0;
        for (int n = 0; n < N_DIR; n++) begin
            t = $random(seed);
            k = {$random(seed)} % W;
            for (int i = 0; i < W; i++) begin
                s = t[i] ? 1 : -1;
                sp = ((i == 0) ? last_true : t[i - 1]) ? 1 : -1;
                c[i] = 40 * s + 20 * sp;
            end
            c[k] = t[k] ? -8'sd5 : 8'sd5;
            last_true = t[W - 1];
            drive_word(c);
        end
        close_test("detector", eb);
        if (flip_cur_seen == 0) begin
            $display("No current-bit flip decision was seen in the directed detector test");
            errors++;
        end
        if (flip_prev_seen == 0) begin
            $display("No previous-bit flip decision was seen in the directed detector test");
            errors++;
        end

        if (exp_q.size() != 0) begin
            $display("Expected words still pending at the end of the run");
            errors++;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : datapath_core_tb

// ==== sim/datapath_core_assert.sv ====
`timescale 1ns/1ns

`include "dsp_defines.svh"

module datapath_core_assert (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      codes_valid_i,
    input logic                      bits_valid,
    input logic                      est_valid,
    input logic                      out_valid_o,
    input dsp_data_pkg::detect_out_t detect_o
);
    import dsp_data_pkg::*;

    // Strobes are held low while reset is active
    property strobes_low_in_reset;
        @(posedge clk) !rst_n_i |-> (!bits_valid && !est_valid && !out_valid_o);
    endproperty
    assert property (strobes_low_in_reset)
        else $error("valid strobe high during reset");

    // Three cycles of latency through the core
    property out_valid_latency;
        @(posedge clk) disable iff (!rst_n_i) out_valid_o == $past(codes_valid_i, 3);
    endproperty
    assert property (out_valid_latency)
        else $error("out_valid_o does not follow codes_valid_i by 3 cycles");

    genvar i;
    generate
        for (i = 0; i < `CHANNEL_WIDTH; i++) begin : g_lane
            assert property (@(posedge clk) detect_o.decisions[i] != 2'd3)
                else $error("decision value 3 on lane %0d", i);
        end
    endgenerate

endmodule : datapath_core_assert

bind datapath_core datapath_core_assert datapath_core_assert_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .codes_valid_i (codes_valid_i),
    .bits_valid    (bits_valid),
    .est_valid     (est_valid),
    .out_valid_o   (out_valid_o),
    .detect_o      (detect_o)
);

// ==== design/datapath_core.sv ====
`timescale 1ns/1ns

module datapath_core (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      codes_valid_i,
    input  dsp_data_pkg::code_word_t  adc_codes_i,
    input  dsp_cfg_pkg::dsp_cfg_t     cfg_i,
    output logic                      out_valid_o,
    output dsp_data_pkg::detect_out_t detect_o
);
    import dsp_data_pkg::*;

    logic           bits_valid;
    bit_word_t      sliced_bits;
    logic           est_valid;
    est_code_word_t est_codes;
    code_word_t     aligned_codes;

    // FFE and slicer
    ffe_slicer ffe_slicer_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .codes_valid_i (codes_valid_i),
        .adc_codes_i   (adc_codes_i),
        .cfg_i         (cfg_i),
        .bits_valid_o  (bits_valid),
        .sliced_bits_o (sliced_bits)
    );

    channel_filter channel_filter_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .bits_valid_i    (bits_valid),
        .sliced_bits_i   (sliced_bits),
        .channel_est_i   (cfg_i.channel_est),
        .channel_shift_i (cfg_i.channel_shift),
        .est_valid_o     (est_valid),
        .est_codes_o     (est_codes)
    );

    // Raw codes lag two valid stages to meet the rebuilt codes
    code_delay_line code_delay_line_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .codes_valid_i   (codes_valid_i),
        .adc_codes_i     (adc_codes_i),
        .aligned_codes_o (aligned_codes)
    );

    error_detector error_detector_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .est_valid_i     (est_valid),
        .est_codes_i     (est_codes),
        .aligned_codes_i (aligned_codes),
        .sliced_bits_i   (sliced_bits),
        .channel_est_i   (cfg_i.channel_est),
        .channel_shift_i (cfg_i.channel_shift),
        .out_valid_o     (out_valid_o),
        .detect_o        (detect_o)
    );

endmodule : datapath_core

// ==== design/error_detector.sv ====
`timescale 1ns/1ns

`include "dsp_defines.svh"

module error_detector (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         est_valid_i,
    input  dsp_data_pkg::est_code_word_t est_codes_i,
    input  dsp_data_pkg::code_word_t     aligned_codes_i,
    input  dsp_data_pkg::bit_word_t      sliced_bits_i,
    input  dsp_cfg_pkg::chan_est_t       channel_est_i,
    input  logic [`SHIFT_PRECISION-1:0]  channel_shift_i,
    output logic                         out_valid_o,
    output dsp_data_pkg::detect_out_t    detect_o
);
    import dsp_data_pkg::*;

    localparam int D_W    = `CHAN_PRECISION + 1;
    localparam int DIFF_W = `ERROR_PRECISION + 2;
    localparam int COST_W = 2 * DIFF_W + 1;

    // Slicer word one cycle late, which is the word just rebuilt on est_valid_i
    bit_word_t   bits_d;
    logic        prev_last_bit;
    error_word_t err;
    mmse_word_t  dec_next;

    logic signed [D_W-1:0] d [2];

    function automatic logic [COST_W-1:0] square(input logic signed [DIFF_W-1:0] x);
        logic signed [COST_W-1:0] p;
        p = x * x;
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            err[i] = est_codes_i[i] - aligned_codes_i[i];
        end
    end

    // Error change caused by flipping one symbol, before its sign
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            d[j] = $signed({channel_est_i[j], 1'b0}) >>> channel_shift_i;
        end
    end

    always_comb begin
        logic signed [DIFF_W-1:0] e_cur;
        logic signed [DIFF_W-1:0] e_nxt;
        logic signed [DIFF_W-1:0] sd0;
        logic signed [DIFF_W-1:0] sd1;
        logic signed [DIFF_W-1:0] sd1_prev;
        logic [COST_W-1:0]        cost0;
        logic [COST_W-1:0]        cost1;
        logic [COST_W-1:0]        cost2;
        logic [COST_W-1:0]        best;
        logic                     s_prev;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            e_cur  = err[i];
            s_prev = (i == 0) ? prev_last_bit : bits_d[(i + `CHANNEL_WIDTH - 1) % `CHANNEL_WIDTH];
            sd0      = bits_d[i] ? d[0] : -d[0];
            sd1      = bits_d[i] ? d[1] : -d[1];
            sd1_prev = s_prev ? d[1] : -d[1];

            cost0 = square(e_cur);
            cost1 = square(e_cur - sd0);
            cost2 = square(e_cur - sd1_prev);
            // Window is cut at the end of the word
            if (i + 1 < `CHANNEL_WIDTH) begin
                e_nxt = err[i + 1];
                cost0 = cost0 + square(e_nxt);
                cost1 = cost1 + square(e_nxt - sd1);
                cost2 = cost2 + square(e_nxt);
            end

            // Ties keep the lower index
            dec_next[i] = MMSE_KEEP;
            best        = cost0;
            if (cost1 < best) begin
                dec_next[i] = MMSE_FLIP_CUR;
                best        = cost1;
            end
            if (cost2 < best) begin
                dec_next[i] = MMSE_FLIP_PREV;
            end
        end
    end

    always_ff @(posedge clk) begin
        bits_d <= sliced_bits_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_last_bit <= 1'b0;
            out_valid_o   <= 1'b0;
            detect_o      <= '0;
        end else begin
            out_valid_o <= est_valid_i;
            if (est_valid_i) begin
                prev_last_bit      <= bits_d[`CHANNEL_WIDTH-1];
                detect_o.bits      <= bits_d;
                detect_o.decisions <= dec_next;
            end
        end
    end

endmodule : error_detector

// ==== design/code_delay_line.sv ====
`timescale 1ns/1ns

module code_delay_line (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     codes_valid_i,
    input  dsp_data_pkg::code_word_t adc_codes_i,
    output dsp_data_pkg::code_word_t aligned_codes_o
);
    import dsp_data_pkg::*;

    code_word_t stage1_codes;
    logic       stage1_valid;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= codes_valid_i;
        end
    end

    // Each stage loads only when its own word moves through
    always_ff @(posedge clk) begin
        if (codes_valid_i) begin
            stage1_codes <= adc_codes_i;
        end
        if (stage1_valid) begin
            aligned_codes_o <= stage1_codes;
        end
    end

endmodule : code_delay_line

// ==== design/channel_filter.sv ====
`timescale 1ns/1ns

`include "dsp_defines.svh"

module channel_filter (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         bits_valid_i,
    input  dsp_data_pkg::bit_word_t      sliced_bits_i,
    input  dsp_cfg_pkg::chan_est_t       channel_est_i,
    input  logic [`SHIFT_PRECISION-1:0]  channel_shift_i,
    output logic                         est_valid_o,
    output dsp_data_pkg::est_code_word_t est_codes_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    // One extra bit since a negated tap can reach +2^(P-1)
    localparam int SUM_W = `CHAN_PRECISION + $clog2(`CHAN_DEPTH) + 1;
    localparam int EST_W = `EST_CODE_PRECISION;

    bit_word_t                       prev_bits;
    logic [2*`CHANNEL_WIDTH-1:0]     ext_bits;
    est_code_word_t                  est_next;

    assign ext_bits = {sliced_bits_i, prev_bits};

    always_comb begin
        logic signed [SUM_W-1:0] acc;
        chan_tap_t               tap;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = '0;
            for (int j = 0; j < `CHAN_DEPTH; j++) begin
                tap = channel_est_i[j];
                // Symbol +1 adds the tap, -1 subtracts it
                if (ext_bits[`CHANNEL_WIDTH + i - j]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            est_next[i] = EST_W'(acc >>> channel_shift_i);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_bits   <= '0;
            est_valid_o <= 1'b0;
            est_codes_o <= '0;
        end else begin
            est_valid_o <= bits_valid_i;
            if (bits_valid_i) begin
                prev_bits   <= sliced_bits_i;
                est_codes_o <= est_next;
            end
        end
    end

endmodule : channel_filter

// ==== design/ffe_slicer.sv ====
`timescale 1ns/1ns

`include "dsp_defines.svh"

module ffe_slicer (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     codes_valid_i,
    input  dsp_data_pkg::code_word_t adc_codes_i,
    input  dsp_cfg_pkg::dsp_cfg_t    cfg_i,
    output logic                     bits_valid_o,
    output dsp_data_pkg::bit_word_t  sliced_bits_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    localparam int SUM_W = `CODE_PRECISION + `WEIGHT_PRECISION + $clog2(`FFE_LENGTH);
    localparam int OUT_W = `FFE_OUT_PRECISION;

    // Last valid word, its lane W-1 directly precedes lane 0 of the current word
    code_word_t prev_codes;

    // Previous word in the low lanes, current word in the high lanes
    code_t [2*`CHANNEL_WIDTH-1:0] ext_codes;

    logic signed [OUT_W-1:0] ffe_out [`CHANNEL_WIDTH];
    bit_word_t               bits_next;

    assign ext_codes = {adc_codes_i, prev_codes};

    always_comb begin
        logic signed [SUM_W-1:0] acc;
        weight_t                 w;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = '0;
            for (int j = 0; j < `FFE_LENGTH; j++) begin
                w = cfg_i.weights[j];
                if (!cfg_i.disable_product[j]) begin
                    acc = acc + w * ext_codes[`CHANNEL_WIDTH + i - j];
                end
            end
            ffe_out[i] = OUT_W'(acc >>> cfg_i.ffe_shift);
        end
    end

    // Slicer
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            bits_next[i] = (ffe_out[i] >= cfg_i.thresh);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_codes    <= '0;
            bits_valid_o  <= 1'b0;
            sliced_bits_o <= '0;
        end else begin
            bits_valid_o <= codes_valid_i;
            // History only advances on valid words
            if (codes_valid_i) begin
                prev_codes    <= adc_codes_i;
                sliced_bits_o <= bits_next;
            end
        end
    end

endmodule : ffe_slicer

// ==== design/dsp_data_pkg.sv ====
`include "dsp_defines.svh"

package dsp_data_pkg;

    // Lane 0 holds the oldest symbol of a word
    typedef logic signed [`CODE_PRECISION-1:0] code_t;
    typedef code_t [`CHANNEL_WIDTH-1:0] code_word_t;

    // 1 stands for +1, 0 for -1
    typedef logic [`CHANNEL_WIDTH-1:0] bit_word_t;

    typedef logic signed [`EST_CODE_PRECISION-1:0] est_code_t;
    typedef est_code_t [`CHANNEL_WIDTH-1:0] est_code_word_t;

    typedef logic signed [`ERROR_PRECISION-1:0] error_t;
    typedef error_t [`CHANNEL_WIDTH-1:0] error_word_t;

    typedef enum logic [1:0] {
        MMSE_KEEP      = 2'd0,
        MMSE_FLIP_CUR  = 2'd1,
        MMSE_FLIP_PREV = 2'd2
    } mmse_pos_t;

    typedef mmse_pos_t [`CHANNEL_WIDTH-1:0] mmse_word_t;

    typedef struct packed {
        bit_word_t  bits;
        mmse_word_t decisions;
    } detect_out_t;

endpackage : dsp_data_pkg

// ==== design/dsp_cfg_pkg.sv ====
`include "dsp_defines.svh"

package dsp_cfg_pkg;

    typedef logic signed [`WEIGHT_PRECISION-1:0] weight_t;
    typedef weight_t [`FFE_LENGTH-1:0] ffe_weights_t;

    // Bit j set drops the product of tap j
    typedef logic [`FFE_LENGTH-1:0] ffe_mask_t;

    typedef logic [`SHIFT_PRECISION-1:0] shift_t;
    typedef logic signed [`FFE_OUT_PRECISION-1:0] thresh_t;

    typedef logic signed [`CHAN_PRECISION-1:0] chan_tap_t;
    typedef chan_tap_t [`CHAN_DEPTH-1:0] chan_est_t;

    // Static settings, held stable while data flows
    typedef struct packed {
        ffe_weights_t weights;
        ffe_mask_t    disable_product;
        shift_t       ffe_shift;
        thresh_t      thresh;
        chan_est_t    channel_est;
        shift_t       channel_shift;
    } dsp_cfg_t;

endpackage : dsp_cfg_pkg

// ==== design/dsp_defines.svh ====
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// Lanes per word
`define CHANNEL_WIDTH 4
`define CODE_PRECISION 8

// FFE
`define FFE_LENGTH 3
`define WEIGHT_PRECISION 8
`define FFE_OUT_PRECISION 10
`define SHIFT_PRECISION 4

// Channel estimate
`define CHAN_DEPTH 3
`define CHAN_PRECISION 8
`define EST_CODE_PRECISION 10

// Rebuilt code minus raw code
`define ERROR_PRECISION 11

`endif
